// File: include/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// datapath sizes, RV32E
`define XLEN      32
`define ILEN      32
`define NREG      16
`define RADDR_W   4

// opcodes of the supported subset
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_BRANCH 7'b1100011
`define OP_IMM    7'b0010011
`define OP_REG    7'b0110011

// funct3 values that decode checks directly
`define F3_ADD    3'b000
`define F3_SLL    3'b001
`define F3_SR     3'b101
`define F3_JALR   3'b000

// funct7 values, ALT selects sub and sra
`define F7_ZERO   7'b0000000
`define F7_ALT    7'b0100000

// link offset for jumps
`define PC_STEP   32'd4

`endif

// File: src/rv_pkg.sv
`include "rv_defines.svh"

package rv_pkg;

  // {funct7[5], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_t;

  // branch funct3, 010 and 011 are not defined
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } br_op_t;

  typedef struct packed {
    logic [`ILEN-1:0] inst;
    logic [`XLEN-1:0] pc;
  } fetch_t;

  typedef struct packed {
    logic [`XLEN-1:0]    pc;
    logic [`XLEN-1:0]    next_pc;
    logic [`RADDR_W-1:0] rd;
    logic [`XLEN-1:0]    data;
    logic                wen;
    logic                illegal;
  } retire_t;

endpackage

// File: src/stage_buf.sv
`timescale 1ns/1ns

module stage_buf #(
  parameter type PAYLOAD_T = logic [31:0]
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     s_valid_i,
  output logic     s_ready_o,
  input  PAYLOAD_T s_data_i,
  output logic     m_valid_o,
  input  logic     m_ready_i,
  output PAYLOAD_T m_data_o
);
  logic     m_valid_q;
  logic     skid_valid_q;
  PAYLOAD_T m_data_q;
  PAYLOAD_T skid_data_q;
  logic     out_free;
  logic     s_fire;

  assign out_free  = !m_valid_q || m_ready_i; // head moves or is empty
  assign s_ready_o = !skid_valid_q; // straight from a flop
  assign s_fire    = s_valid_i && s_ready_o;
  assign m_valid_o = m_valid_q;
  assign m_data_o  = m_data_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      m_valid_q    <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (out_free) begin
      m_valid_q    <= skid_valid_q || s_fire;
      skid_valid_q <= 1'b0;
    end else if (s_fire) begin
      skid_valid_q <= 1'b1; // head stalled, park the word
    end
  end

  always_ff @(posedge clk) begin
    if (out_free) begin
      m_data_q <= skid_valid_q ? skid_data_q : s_data_i;
    end
    if (!out_free && s_fire) begin
      skid_data_q <= s_data_i;
    end
  end

  // held head must not change under back-pressure
  a_hold: assert property (@(posedge clk) disable iff (rst)
    m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_data_o));

  // a refused word waits at the input until taken
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    s_valid_i && !s_ready_o |=> s_valid_i && $stable(s_data_i));

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ns
`include "rv_defines.svh"

module reg_file (
  input  logic                clk,
  input  logic                rst,
  input  logic [`RADDR_W-1:0] raddr1_i,
  input  logic [`RADDR_W-1:0] raddr2_i,
  output logic [`XLEN-1:0]    rdata1_o,
  output logic [`XLEN-1:0]    rdata2_o,
  output logic                busy1_o,
  output logic                busy2_o,
  input  logic                set_busy_i,
  input  logic [`RADDR_W-1:0] set_addr_i,
  input  logic                wen_i,
  input  logic [`RADDR_W-1:0] waddr_i,
  input  logic [`XLEN-1:0]    wdata_i
);
  logic [`XLEN-1:0] regs [`NREG];
  logic [`NREG-1:0] busy_q;
  logic [`NREG-1:0] busy_d;
  logic             byp1;
  logic             byp2;

  // write in flight this cycle is forwarded
  assign byp1 = wen_i && (waddr_i == raddr1_i);
  assign byp2 = wen_i && (waddr_i == raddr2_i);

  assign rdata1_o = (raddr1_i == '0) ? '0 : byp1 ? wdata_i : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : byp2 ? wdata_i : regs[raddr2_i];

  assign busy1_o = busy_q[raddr1_i] && !byp1; // clear wins over busy
  assign busy2_o = busy_q[raddr2_i] && !byp2;

  always_comb begin
    busy_d = busy_q;
    if (wen_i) begin
      busy_d[waddr_i] = 1'b0;
    end
    // new writer issued on the same edge keeps it pending
    if (set_busy_i) begin
      busy_d[set_addr_i] = 1'b1;
    end
    busy_d[0] = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= '0;
    end else begin
      busy_q <= busy_d;
    end
  end

  always_ff @(posedge clk) begin
    if (wen_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // execute only retires writes that decode marked pending
  a_write_busy: assert property (@(posedge clk) disable iff (rst)
    wen_i |-> (waddr_i != '0) && busy_q[waddr_i]);

endmodule

// File: src/inst_decode.sv
`timescale 1ns/1ns
`include "rv_defines.svh"

module inst_decode (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  logic [`ILEN-1:0]    inst_i,
  input  logic [`XLEN-1:0]    pc_i,
  output logic [`RADDR_W-1:0] raddr1_o,
  output logic [`RADDR_W-1:0] raddr2_o,
  input  logic [`XLEN-1:0]    rdata1_i,
  input  logic [`XLEN-1:0]    rdata2_i,
  input  logic                busy1_i,
  input  logic                busy2_i,
  output logic                set_busy_o,
  output logic [`RADDR_W-1:0] set_addr_o,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output logic [`XLEN-1:0]    pc_o,
  output logic [`RADDR_W-1:0] rd_o,
  output logic                wen_o,
  output rv_pkg::alu_op_t     alu_op_o,
  output rv_pkg::br_op_t      br_op_o,
  output logic                is_branch_o,
  output logic                is_jump_o,
  output logic [`XLEN-1:0]    op1_o,
  output logic [`XLEN-1:0]    op2_o,
  output logic [`XLEN-1:0]    base_o,
  output logic [`XLEN-1:0]    imm_o,
  output logic                illegal_o
);
  import rv_pkg::*;

  logic             valid_q;
  logic [`ILEN-1:0] inst_q;
  logic [`XLEN-1:0] pc_q;
  logic [6:0]       opcode;
  logic [4:0]       rs1;
  logic [4:0]       rs2;
  logic [4:0]       rd;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_j;
  logic             uses_rs1;
  logic             uses_rs2;
  logic             uses_rd;
  logic             known;
  logic             bad_funct;
  logic             bad_reg;
  logic             is_br;
  logic             is_jmp;
  logic             conflict;
  logic             issue;

  assign opcode = inst_q[6:0];
  assign rd     = inst_q[11:7];
  assign funct3 = inst_q[14:12];
  assign rs1    = inst_q[19:15];
  assign rs2    = inst_q[24:20];
  assign funct7 = inst_q[31:25];

  assign imm_i = {{20{inst_q[31]}}, inst_q[31:20]};
  assign imm_u = {inst_q[31:12], 12'b0};
  assign imm_b = {{19{inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
  assign imm_j = {{11{inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};

  always_comb begin
    uses_rs1  = 1'b0;
    uses_rs2  = 1'b0;
    uses_rd   = 1'b0;
    known     = 1'b1;
    bad_funct = 1'b0;
    is_br     = 1'b0;
    is_jmp    = 1'b0;
    alu_op_o  = ALU_ADD;
    op1_o     = '0;
    op2_o     = '0;
    base_o    = pc_q; // jal and branches target from pc
    imm_o     = '0;
    case (opcode)
      `OP_LUI: begin
        uses_rd = 1'b1;
        op2_o   = imm_u;
        imm_o   = imm_u;
      end
      `OP_AUIPC: begin
        uses_rd = 1'b1;
        op1_o   = pc_q;
        op2_o   = imm_u;
        imm_o   = imm_u;
      end
      `OP_JAL: begin
        uses_rd = 1'b1;
        is_jmp  = 1'b1;
        op1_o   = pc_q;
        op2_o   = `PC_STEP; // link value
        imm_o   = imm_j;
      end
      `OP_JALR: begin
        uses_rs1  = 1'b1;
        uses_rd   = 1'b1;
        is_jmp    = 1'b1;
        op1_o     = pc_q;
        op2_o     = `PC_STEP;
        base_o    = rdata1_i;
        imm_o     = imm_i;
        bad_funct = (funct3 != `F3_JALR);
      end
      `OP_BRANCH: begin
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
        is_br     = 1'b1;
        op1_o     = rdata1_i;
        op2_o     = rdata2_i;
        imm_o     = imm_b;
        bad_funct = (funct3[2:1] == 2'b01);
      end
      `OP_IMM: begin
        uses_rs1  = 1'b1;
        uses_rd   = 1'b1;
        op1_o     = rdata1_i;
        op2_o     = imm_i;
        imm_o     = imm_i;
        // funct7[5] only means sra on the right shift
        alu_op_o  = alu_op_t'({(funct3 == `F3_SR) ? funct7[5] : 1'b0, funct3});
        bad_funct = ((funct3 == `F3_SLL) && (funct7 != `F7_ZERO)) ||
                    ((funct3 == `F3_SR) && (funct7 != `F7_ZERO) && (funct7 != `F7_ALT));
      end
      `OP_REG: begin
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
        uses_rd   = 1'b1;
        op1_o     = rdata1_i;
        op2_o     = rdata2_i;
        alu_op_o  = alu_op_t'({funct7[5], funct3});
        bad_funct = !((funct7 == `F7_ZERO) ||
                      ((funct7 == `F7_ALT) && ((funct3 == `F3_ADD) || (funct3 == `F3_SR))));
      end
      default: known = 1'b0;
    endcase
  end

  // rv32e has no x16..x31
  assign bad_reg   = (uses_rs1 && rs1[4]) || (uses_rs2 && rs2[4]) || (uses_rd && rd[4]);
  assign illegal_o = !known || bad_funct || bad_reg;

  assign raddr1_o    = rs1[`RADDR_W-1:0];
  assign raddr2_o    = rs2[`RADDR_W-1:0];
  assign pc_o        = pc_q;
  assign rd_o        = rd[`RADDR_W-1:0];
  assign wen_o       = uses_rd && !illegal_o && (rd != '0);
  assign br_op_o     = br_op_t'(funct3);
  assign is_branch_o = is_br && !illegal_o;
  assign is_jump_o   = is_jmp && !illegal_o;

  assign conflict    = !illegal_o && ((uses_rs1 && busy1_i) || (uses_rs2 && busy2_i));
  assign out_valid_o = valid_q && !conflict;
  assign issue       = out_valid_o && out_ready_i;
  assign in_ready_o  = !valid_q || issue;
  assign set_busy_o  = issue && wen_o; // rd pending until execute writes
  assign set_addr_o  = rd_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      inst_q <= inst_i;
      pc_q   <= pc_i;
    end
  end

endmodule

// File: src/exec_unit.sv
`timescale 1ns/1ns
`include "rv_defines.svh"

module exec_unit (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  logic [`XLEN-1:0]    pc_i,
  input  logic [`RADDR_W-1:0] rd_i,
  input  logic                wen_i,
  input  rv_pkg::alu_op_t     alu_op_i,
  input  rv_pkg::br_op_t      br_op_i,
  input  logic                is_branch_i,
  input  logic                is_jump_i,
  input  logic [`XLEN-1:0]    op1_i,
  input  logic [`XLEN-1:0]    op2_i,
  input  logic [`XLEN-1:0]    base_i,
  input  logic [`XLEN-1:0]    imm_i,
  input  logic                illegal_i,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output rv_pkg::retire_t     out_data_o,
  output logic                reg_wen_o,
  output logic [`RADDR_W-1:0] reg_waddr_o,
  output logic [`XLEN-1:0]    reg_wdata_o
);
  import rv_pkg::*;

  logic [`XLEN-1:0] alu_res;
  logic [4:0]       shamt;
  logic             taken;
  logic [`XLEN-1:0] target;
  logic             valid_q;
  logic             in_fire;
  retire_t          rec_d;
  retire_t          rec_q;

  assign shamt = op2_i[4:0];

  always_comb begin
    case (alu_op_i)
      ALU_ADD:  alu_res = op1_i + op2_i;
      ALU_SUB:  alu_res = op1_i - op2_i;
      ALU_SLL:  alu_res = op1_i << shamt;
      ALU_SLT:  alu_res = {{(`XLEN-1){1'b0}}, $signed(op1_i) < $signed(op2_i)};
      ALU_SLTU: alu_res = {{(`XLEN-1){1'b0}}, op1_i < op2_i};
      ALU_XOR:  alu_res = op1_i ^ op2_i;
      ALU_SRL:  alu_res = op1_i >> shamt;
      ALU_SRA:  alu_res = $signed(op1_i) >>> shamt;
      ALU_OR:   alu_res = op1_i | op2_i;
      ALU_AND:  alu_res = op1_i & op2_i;
      default:  alu_res = '0;
    endcase
  end

  always_comb begin
    case (br_op_i)
      BR_EQ:   taken = (op1_i == op2_i);
      BR_NE:   taken = (op1_i != op2_i);
      BR_LT:   taken = ($signed(op1_i) < $signed(op2_i));
      BR_GE:   taken = ($signed(op1_i) >= $signed(op2_i));
      BR_LTU:  taken = (op1_i < op2_i);
      BR_GEU:  taken = (op1_i >= op2_i);
      default: taken = 1'b0;
    endcase
  end

  // bit 0 only ever set by jalr
  assign target = (base_i + imm_i) & ~`XLEN'(1);

  always_comb begin
    rec_d.pc      = pc_i;
    rec_d.next_pc = (is_jump_i || (is_branch_i && taken)) ? target : pc_i + `PC_STEP;
    rec_d.rd      = rd_i;
    rec_d.data    = (is_branch_i || illegal_i) ? '0 : alu_res;
    rec_d.wen     = wen_i;
    rec_d.illegal = illegal_i;
  end

  assign in_ready_o  = !valid_q || out_ready_i;
  assign in_fire     = in_valid_i && in_ready_o;
  assign out_valid_o = valid_q;
  assign out_data_o  = rec_q;

  // write back on hand-off to the output buffer
  assign reg_wen_o   = valid_q && out_ready_i && rec_q.wen;
  assign reg_waddr_o = rec_q.rd;
  assign reg_wdata_o = rec_q.data;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      rec_q <= rec_d;
    end
  end

  // decode must never hand over a writing branch or illegal op
  a_no_bad_write: assert property (@(posedge clk) disable iff (rst)
    in_fire && (is_branch_i || illegal_i) |=> !out_data_o.wen);

endmodule

// File: src/rv_core.sv
`timescale 1ns/1ns
`include "rv_defines.svh"

module rv_core (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  logic [`ILEN-1:0]    inst_i,
  input  logic [`XLEN-1:0]    pc_i,
  output logic                ret_valid_o,
  input  logic                ret_ready_i,
  output logic [`XLEN-1:0]    ret_pc_o,
  output logic [`XLEN-1:0]    ret_next_pc_o,
  output logic [`RADDR_W-1:0] ret_rd_o,
  output logic [`XLEN-1:0]    ret_data_o,
  output logic                ret_wen_o,
  output logic                ret_illegal_o
);
  import rv_pkg::*;

  fetch_t              fetch_in;
  fetch_t              fetch_q;
  logic                fetch_valid;
  logic                fetch_ready;
  logic [`RADDR_W-1:0] raddr1;
  logic [`RADDR_W-1:0] raddr2;
  logic [`XLEN-1:0]    rdata1;
  logic [`XLEN-1:0]    rdata2;
  logic                busy1;
  logic                busy2;
  logic                set_busy;
  logic [`RADDR_W-1:0] set_addr;
  logic                dec_valid;
  logic                dec_ready;
  logic [`XLEN-1:0]    dec_pc;
  logic [`RADDR_W-1:0] dec_rd;
  logic                dec_wen;
  alu_op_t             dec_alu_op;
  br_op_t              dec_br_op;
  logic                dec_is_branch;
  logic                dec_is_jump;
  logic [`XLEN-1:0]    dec_op1;
  logic [`XLEN-1:0]    dec_op2;
  logic [`XLEN-1:0]    dec_base;
  logic [`XLEN-1:0]    dec_imm;
  logic                dec_illegal;
  logic                ex_valid;
  logic                ex_ready;
  retire_t             ex_rec;
  logic                wb_wen;
  logic [`RADDR_W-1:0] wb_addr;
  logic [`XLEN-1:0]    wb_data;
  retire_t             ret_rec;

  assign fetch_in.inst = inst_i;
  assign fetch_in.pc   = pc_i;

  stage_buf #(.PAYLOAD_T(fetch_t)) i_in_buf (
    .clk(clk), .rst(rst),
    .s_valid_i(in_valid_i), .s_ready_o(in_ready_o), .s_data_i(fetch_in),
    .m_valid_o(fetch_valid), .m_ready_i(fetch_ready), .m_data_o(fetch_q)
  );

  inst_decode i_inst_decode (
    .clk(clk), .rst(rst),
    .in_valid_i(fetch_valid), .in_ready_o(fetch_ready),
    .inst_i(fetch_q.inst), .pc_i(fetch_q.pc),
    .raddr1_o(raddr1), .raddr2_o(raddr2), .rdata1_i(rdata1), .rdata2_i(rdata2),
    .busy1_i(busy1), .busy2_i(busy2), .set_busy_o(set_busy), .set_addr_o(set_addr),
    .out_valid_o(dec_valid), .out_ready_i(dec_ready),
    .pc_o(dec_pc), .rd_o(dec_rd), .wen_o(dec_wen),
    .alu_op_o(dec_alu_op), .br_op_o(dec_br_op),
    .is_branch_o(dec_is_branch), .is_jump_o(dec_is_jump),
    .op1_o(dec_op1), .op2_o(dec_op2), .base_o(dec_base), .imm_o(dec_imm),
    .illegal_o(dec_illegal)
  );

  reg_file i_reg_file (
    .clk(clk), .rst(rst),
    .raddr1_i(raddr1), .raddr2_i(raddr2), .rdata1_o(rdata1), .rdata2_o(rdata2),
    .busy1_o(busy1), .busy2_o(busy2), .set_busy_i(set_busy), .set_addr_i(set_addr),
    .wen_i(wb_wen), .waddr_i(wb_addr), .wdata_i(wb_data)
  );

  exec_unit i_exec_unit (
    .clk(clk), .rst(rst),
    .in_valid_i(dec_valid), .in_ready_o(dec_ready),
    .pc_i(dec_pc), .rd_i(dec_rd), .wen_i(dec_wen),
    .alu_op_i(dec_alu_op), .br_op_i(dec_br_op),
    .is_branch_i(dec_is_branch), .is_jump_i(dec_is_jump),
    .op1_i(dec_op1), .op2_i(dec_op2), .base_i(dec_base), .imm_i(dec_imm),
    .illegal_i(dec_illegal),
    .out_valid_o(ex_valid), .out_ready_i(ex_ready), .out_data_o(ex_rec),
    .reg_wen_o(wb_wen), .reg_waddr_o(wb_addr), .reg_wdata_o(wb_data)
  );

  stage_buf #(.PAYLOAD_T(retire_t)) i_out_buf (
    .clk(clk), .rst(rst),
    .s_valid_i(ex_valid), .s_ready_o(ex_ready), .s_data_i(ex_rec),
    .m_valid_o(ret_valid_o), .m_ready_i(ret_ready_i), .m_data_o(ret_rec)
  );

  assign ret_pc_o      = ret_rec.pc;
  assign ret_next_pc_o = ret_rec.next_pc;
  assign ret_rd_o      = ret_rec.rd;
  assign ret_data_o    = ret_rec.data;
  assign ret_wen_o     = ret_rec.wen;
  assign ret_illegal_o = ret_rec.illegal;

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD     = 100,
  parameter int RST_CYCLES = 4
) (
  output logic clk,
  output logic rst
);
  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst <= 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0; // released right after the last reset edge
  end

endmodule

// File: bench/tb_core.sv
`timescale 1ns/1ns
`include "rv_defines.svh"

module tb_core;
  localparam int          N_INST  = 400;
  localparam int          TIMEOUT = 10 * N_INST + 100;
  localparam logic [31:0] SEED    = 32'd37;

  logic        clk;
  logic        rst;
  logic        in_valid_i;
  logic        in_ready_o;
  logic [31:0] inst_i;
  logic [31:0] pc_i;
  logic        ret_valid_o;
  logic        ret_ready_i;
  logic [31:0] ret_pc_o;
  logic [31:0] ret_next_pc_o;
  logic [3:0]  ret_rd_o;
  logic [31:0] ret_data_o;
  logic        ret_wen_o;
  logic        ret_illegal_o;
  logic        ret_fire;

  logic [31:0] lfsr_q;
  logic [3:0]  last_rd;
  logic [31:0] mregs [16]; // architectural state of the model
  logic [31:0] q_inst [$];
  logic [31:0] q_pc [$];
  int          cycles;
  int          retired;
  logic        have_exp;
  logic [31:0] exp_pc;
  logic [31:0] exp_next_pc;
  logic [3:0]  exp_rd;
  logic [31:0] exp_data;
  logic        exp_wen;
  logic        exp_illegal;

  tb_clock #(.PERIOD(100), .RST_CYCLES(4)) i_tb_clock (.clk(clk), .rst(rst));

  rv_core i_rv_core (
    .clk(clk), .rst(rst),
    .in_valid_i(in_valid_i), .in_ready_o(in_ready_o), .inst_i(inst_i), .pc_i(pc_i),
    .ret_valid_o(ret_valid_o), .ret_ready_i(ret_ready_i),
    .ret_pc_o(ret_pc_o), .ret_next_pc_o(ret_next_pc_o), .ret_rd_o(ret_rd_o),
    .ret_data_o(ret_data_o), .ret_wen_o(ret_wen_o), .ret_illegal_o(ret_illegal_o)
  );

  assign ret_fire = ret_valid_o && ret_ready_i;

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("FAIL %s expected %h actual %h", name, exp, act);
    $display("Test failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic report_error(input string what);
    $display("ERROR %s", what);
    $display("Test failed");
    $fatal(1, "stopping at the first error");
  endtask

  // galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] x, input logic [31:0] y);
    logic [4:0] sh;
    sh = y[4:0];
    case (f3)
      3'b000:  return alt ? x - y : x + y;
      3'b001:  return x << sh;
      3'b010:  return {31'b0, $signed(x) < $signed(y)};
      3'b011:  return {31'b0, x < y};
      3'b100:  return x ^ y;
      3'b101: begin
        if (alt) begin
          return $signed(x) >>> sh; // sign fill
        end
        return x >> sh;
      end
      3'b110:  return x | y;
      default: return x & y;
    endcase
  endfunction

  task automatic make_inst(output logic [31:0] inst);
    logic [31:0] r;
    logic [3:0]  kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    r    = take_bits(4);
    kind = r[3:0];
    r    = take_bits(4);
    rd   = {1'b0, r[3:0]};
    r    = take_bits(5);
    rs1  = r[4] ? {1'b0, last_rd} : {1'b0, r[3:0]}; // short dependent chains
    r    = take_bits(4);
    rs2  = {1'b0, r[3:0]};
    r    = take_bits(3);
    f3   = r[2:0];
    r    = take_bits(20);
    case (kind)
      4'd0: inst = {r[19:0], rd, `OP_LUI};
      4'd1: inst = {r[19:0], rd, `OP_AUIPC};
      4'd2: inst = {r[19:0], rd, `OP_JAL};
      4'd3: inst = {r[11:0], rs1, 3'b000, rd, `OP_JALR};
      4'd4, 4'd5: begin
        if (f3[2:1] == 2'b01) begin
          f3[2:1] = 2'b10;
        end
        inst = {r[6:0], rs2, rs1, f3, r[11:7], `OP_BRANCH};
      end
      4'd6, 4'd7, 4'd8, 4'd9: begin
        f7 = r[11:5];
        if (f3 == 3'b001) begin
          f7 = 7'h00;
        end
        if (f3 == 3'b101) begin
          f7 = r[0] ? 7'h20 : 7'h00;
        end
        inst = {f7, r[4:0], rs1, f3, rd, `OP_IMM};
      end
      4'd10, 4'd11, 4'd12, 4'd13: begin
        f7   = (r[0] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
        inst = {f7, rs2, rs1, f3, rd, `OP_REG};
      end
      4'd14: inst = {r[19:0], rd, 7'b0000011}; // load, not supported
      default: inst = {7'h00, rs2, rs1, f3, 1'b1, rd[3:0], `OP_REG}; // rd above x15
    endcase
    last_rd = rd[3:0];
  endtask

  // expected record from the isa rules and the model registers
  task automatic predict(input logic [31:0] inst, input logic [31:0] pc,
                         output logic [31:0] nxt, output logic [31:0] data,
                         output logic wen, output logic ill);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic        writes;
    logic        taken;
    rd     = inst[11:7];
    f3     = inst[14:12];
    rs1    = inst[19:15];
    rs2    = inst[24:20];
    f7     = inst[31:25];
    a      = mregs[rs1[3:0]];
    b      = mregs[rs2[3:0]];
    imm_i  = {{20{inst[31]}}, inst[31:20]};
    nxt    = pc + 32'd4;
    data   = '0;
    writes = 1'b1;
    ill    = 1'b0;
    taken  = 1'b0;
    case (inst[6:0])
      `OP_LUI: begin
        data = {inst[31:12], 12'h000};
        ill  = rd[4];
      end
      `OP_AUIPC: begin
        data = pc + {inst[31:12], 12'h000};
        ill  = rd[4];
      end
      `OP_JAL: begin
        data = pc + 32'd4;
        nxt  = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        ill  = rd[4];
      end
      `OP_JALR: begin
        data = pc + 32'd4;
        nxt  = (a + imm_i) & 32'hffff_fffe;
        ill  = rd[4] || rs1[4] || (f3 != 3'b000);
      end
      `OP_BRANCH: begin
        writes = 1'b0;
        case (f3)
          3'b000:  taken = (a == b);
          3'b001:  taken = (a != b);
          3'b100:  taken = ($signed(a) < $signed(b));
          3'b101:  taken = ($signed(a) >= $signed(b));
          3'b110:  taken = (a < b);
          3'b111:  taken = (a >= b);
          default: taken = 1'b0;
        endcase
        ill = rs1[4] || rs2[4] || (f3[2:1] == 2'b01);
        if (taken) begin
          nxt = pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        end
      end
      `OP_IMM: begin
        data = alu_ref(f3, (f3 == 3'b101) && inst[30], a, imm_i);
        ill  = rs1[4] || rd[4] || ((f3 == 3'b001) && (f7 != 7'h00)) ||
               ((f3 == 3'b101) && (f7 != 7'h00) && (f7 != 7'h20));
      end
      `OP_REG: begin
        data = alu_ref(f3, inst[30], a, b);
        ill  = rs1[4] || rs2[4] || rd[4] ||
               !((f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'b000 || f3 == 3'b101)));
      end
      default: ill = 1'b1;
    endcase
    if (ill) begin
      nxt  = pc + 32'd4;
      data = '0;
    end
    wen = writes && !ill && (rd != 5'd0);
  endtask

  initial begin
    int          sent;
    logic [31:0] inst;
    logic [31:0] pc;
    sent    = 0;
    pc      = 32'h0000_1000;
    lfsr_q  = SEED;
    last_rd = '0;
    in_valid_i  <= 1'b0;
    inst_i      <= '0;
    pc_i        <= '0;
    ret_ready_i <= 1'b0;
    do begin
      @(posedge clk);
    end while (rst);
    forever begin
      if (in_valid_i && in_ready_o) begin
        sent++;
      end
      ret_ready_i <= (take_bits(2) != 0);
      if (!in_valid_i || in_ready_o) begin
        if ((sent < N_INST) && (take_bits(3) != 0)) begin
          make_inst(inst);
          in_valid_i <= 1'b1;
          inst_i     <= inst;
          pc_i       <= pc;
          pc = pc + 32'd4;
        end else begin
          in_valid_i <= 1'b0; // gap
        end
      end
      @(posedge clk);
    end
  end

  always @(posedge clk) begin
    logic [31:0] head;
    logic [31:0] nxt;
    logic [31:0] data;
    logic        wen;
    logic        ill;
    if (rst) begin
      q_inst.delete();
      q_pc.delete();
      for (int i = 0; i < 16; i++) begin
        mregs[i] = '0;
      end
      cycles   = 0;
      retired  = 0;
      have_exp <= 1'b0;
    end else if (retired == N_INST) begin
      if (!ret_valid_o) begin
        $display("Test passed");
        $finish;
      end else begin
        report_error("extra retire record offered after the last instruction");
      end
    end else if (cycles >= TIMEOUT) begin
      report_error("timed out waiting for instructions to retire");
    end else begin
      cycles = cycles + 1;
      if (ret_fire && (q_inst.size() != 0)) begin
        if (exp_wen) begin
          mregs[exp_rd] = exp_data;
        end
        void'(q_inst.pop_front());
        void'(q_pc.pop_front());
        retired = retired + 1;
      end
      if (in_valid_i && in_ready_o) begin
        q_inst.push_back(inst_i);
        q_pc.push_back(pc_i);
      end
      if (q_inst.size() != 0) begin
        head = q_inst[0];
        predict(head, q_pc[0], nxt, data, wen, ill);
        exp_pc      <= q_pc[0];
        exp_next_pc <= nxt;
        exp_rd      <= head[10:7];
        exp_data    <= data;
        exp_wen     <= wen;
        exp_illegal <= ill;
        have_exp    <= 1'b1;
      end else begin
        have_exp <= 1'b0;
      end
    end
  end

  a_known: assert property (@(posedge clk) disable iff (rst) ret_fire |-> have_exp)
    else report_error("retire with no instruction outstanding");

  a_pc: assert property (@(posedge clk) disable iff (rst) ret_fire |-> ret_pc_o == exp_pc)
    else report_mismatch("retire_pc", $sampled(exp_pc), $sampled(ret_pc_o));

  a_next_pc: assert property (@(posedge clk) disable iff (rst)
    ret_fire |-> ret_next_pc_o == exp_next_pc)
    else report_mismatch("retire_next_pc", $sampled(exp_next_pc), $sampled(ret_next_pc_o));

  a_data: assert property (@(posedge clk) disable iff (rst) ret_fire |-> ret_data_o == exp_data)
    else report_mismatch("retire_data", $sampled(exp_data), $sampled(ret_data_o));

  a_wen: assert property (@(posedge clk) disable iff (rst) ret_fire |-> ret_wen_o == exp_wen)
    else report_mismatch("retire_wen", 32'($sampled(exp_wen)), 32'($sampled(ret_wen_o)));

  a_illegal: assert property (@(posedge clk) disable iff (rst)
    ret_fire |-> ret_illegal_o == exp_illegal)
    else report_mismatch("retire_illegal", 32'($sampled(exp_illegal)),
                         32'($sampled(ret_illegal_o)));

  a_rd: assert property (@(posedge clk) disable iff (rst)
    ret_fire && exp_wen |-> ret_rd_o == exp_rd)
    else report_mismatch("retire_rd", 32'($sampled(exp_rd)), 32'($sampled(ret_rd_o)));

  // stalled record must be held as is
  a_hold: assert property (@(posedge clk) disable iff (rst)
    ret_valid_o && !ret_ready_i |=> ret_valid_o &&
    $stable({ret_pc_o, ret_next_pc_o, ret_rd_o, ret_data_o, ret_wen_o, ret_illegal_o}))
    else report_error("retire outputs changed while ret_ready_i was low");

  a_reset: assert property (@(posedge clk) $fell(rst) |-> in_ready_o && !ret_valid_o)
    else report_error("core not idle right after reset");

endmodule

// File: flist.f
+incdir+include
src/rv_pkg.sv
src/stage_buf.sv
src/reg_file.sv
src/inst_decode.sv
src/exec_unit.sv
src/rv_core.sv
bench/tb_clock.sv
bench/tb_core.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_core
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
